//--- fm_chip.f
+incdir+source
source/fm_chip_pkg.sv
source/fm_cpu_sync.sv
source/fm_write_capture.sv
source/fm_timers.sv
source/fm_chip_top.sv
tests/fm_chip_checker.sv
tests/fm_chip_properties.sv
tests/fm_chip_tb.sv

//--- Bender.yml
package:
  name: fm_chip

sources:
  - include_dirs:
      - source
    files:
      - source/fm_chip_pkg.sv
      - source/fm_cpu_sync.sv
      - source/fm_write_capture.sv
      - source/fm_timers.sv
      - source/fm_chip_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/fm_chip_checker.sv
      - tests/fm_chip_properties.sv
      - tests/fm_chip_tb.sv

//--- tests/fm_chip_tb.sv
`timescale 1ns/10ps
`include "fm_chip_macros.svh"

module fm_chip_tb;

	import fm_chip_pkg::*;

	localparam real CPU_NS     = 8.0;
	localparam real SYN_NS     = 20.0;
	localparam int  POLL_LIMIT = 200;
	localparam int  LONGEST    = (1024 + 256 * `FM_TIMER_B_DIV) * `FM_PRESCALE;
	localparam real WATCHDOG_NS = LONGEST * 4 * SYN_NS + 20000.0;

	logic        cpu_clk = 1'b0;
	logic        syn_clk = 1'b0;
	logic        rst;
	logic [7:0]  cpu_din;
	logic [1:0]  cpu_addr;
	logic        cpu_cs_n;
	logic        cpu_wr_n;
	logic [7:0]  cpu_dout;
	logic        cpu_irq_n;
	logic [31:0] lfsr = 32'h66e4_dc23;
	realtime     wr_t; // detect edge of the last write
	logic [31:0] v;
	int          cyc_a;
	int          cyc_b;
	int          cyc_max;

	always #(CPU_NS / 2) cpu_clk = ~cpu_clk;
	always #(SYN_NS / 2) syn_clk = ~syn_clk; // unrelated to cpu_clk

	fm_chip_top dut (.*);

	fm_chip_checker chk (.cpu_clk(cpu_clk), .cpu_dout(cpu_dout), .cpu_irq_n(cpu_irq_n));

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic write_port(input bit part, input bit data_port, input logic [7:0] val,
		input string name);
		@(posedge cpu_clk);
		#1;
		cpu_addr = {part, data_port};
		cpu_din  = val;
		cpu_cs_n = 1'b0;
		cpu_wr_n = 1'b0;
		@(posedge cpu_clk);
		wr_t = $realtime;
		#1;
		cpu_wr_n = 1'b1; // cs_n stays low, now a status read
		chk.poll_busy(name, POLL_LIMIT);
		@(posedge cpu_clk);
		#1;
		cpu_cs_n = 1'b1;
	endtask

	task automatic write_reg(input bit part, input logic [7:0] idx, input logic [7:0] val,
		input string name);
		write_port(part, 1'b0, idx, {name, "_addr"});
		write_port(part, 1'b1, val, {name, "_data"});
	endtask

	task automatic read_status(input string name, input logic [7:0] exp);
		@(posedge cpu_clk);
		#1;
		cpu_cs_n = 1'b0;
		chk.check_status(name, exp);
		@(posedge cpu_clk);
		#1;
		cpu_cs_n = 1'b1;
	endtask

	task automatic run_timer(input bit is_b, input string name, output int cyc);
		logic [31:0] val;
		take_bits(is_b ? 8 : 10, val);
		cyc = chk.timer_cycles(is_b, val);
		if (is_b) begin
			write_reg(1'b0, REG_TIMER_B, val[7:0], {name, "_val"});
		end else begin
			write_reg(1'b0, REG_TIMER_A_HI, val[9:2], {name, "_hi"});
			write_reg(1'b0, REG_TIMER_A_LO, {6'b0, val[1:0]}, {name, "_lo"});
		end
		chk.arm_irq();
		write_reg(1'b0, REG_TIMER_CTRL, is_b ? 8'h0A : 8'h05, {name, "_run"});
		chk.check_timer(name, wr_t, cyc);
		repeat (2) @(posedge cpu_clk); // flags pass two flops into cpu_clk
		read_status({name, "_status"}, is_b ? 8'h02 : 8'h01);
		write_reg(1'b0, REG_TIMER_CTRL, 8'h30, {name, "_stop"}); // stop, clear both flags
		chk.check_irq({name, "_irq_clear"}, 1'b1);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rst      = 1'b1;
		cpu_din  = 8'h00;
		cpu_addr = 2'b00;
		cpu_cs_n = 1'b1;
		cpu_wr_n = 1'b1;
		repeat (8) @(posedge cpu_clk);
		#1;
		rst = 1'b0;
		repeat (10) @(posedge cpu_clk); // let syn_rst drop

		read_status("reset_status", 8'h00);
		chk.check_status("open_bus", 8'hFF);
		chk.check_irq("reset_irq", 1'b1);

		repeat (8) begin
			take_bits(8, v);
			write_reg(1'b0, REG_TIMER_B, v[7:0], "random_write");
		end

		run_timer(1'b0, "timer_a", cyc_a);
		run_timer(1'b1, "timer_b", cyc_b);
		cyc_max = (cyc_a > cyc_b) ? cyc_a : cyc_b;

		// both flags up, then clear one at a time
		write_reg(1'b0, REG_TIMER_CTRL, 8'h0F, "both_run");
		@(posedge cpu_clk);
		#1;
		cpu_cs_n = 1'b0;
		chk.wait_status("both_flags", 8'h03, wr_t + (cyc_max + 40) * SYN_NS);
		@(posedge cpu_clk);
		#1;
		cpu_cs_n = 1'b1;
		write_reg(1'b0, REG_TIMER_CTRL, 8'h1A, "reset_a"); // A stopped, B kept
		read_status("only_flag_b", 8'h02);
		chk.check_irq("irq_held_by_b", 1'b0);
		write_reg(1'b0, REG_TIMER_CTRL, 8'h20, "reset_b");
		read_status("flags_clear", 8'h00);
		chk.check_irq("irq_released", 1'b1);

		// running with flags disabled
		chk.arm_irq();
		write_reg(1'b0, REG_TIMER_CTRL, 8'h03, "run_disabled");
		repeat (2 * cyc_max + 40) @(posedge syn_clk);
		chk.check_no_irq("disabled_no_irq");
		read_status("disabled_status", 8'h00);
		write_reg(1'b0, REG_TIMER_CTRL, 8'h00, "stop_all");

		// part 1 control write with a one tick timer A
		write_reg(1'b0, REG_TIMER_A_HI, 8'hFF, "part0_a_hi");
		write_reg(1'b0, REG_TIMER_A_LO, 8'h03, "part0_a_lo");
		chk.arm_irq();
		write_reg(1'b1, REG_TIMER_CTRL, 8'h05, "part1_ctrl");
		repeat (100) @(posedge syn_clk);
		chk.check_no_irq("part1_no_irq");
		read_status("part1_status", 8'h00);

		$display("tests passed %0d failed %0d assertion failures %0d", chk.pass_cnt,
			chk.fail_cnt, dut.u_cpu_sync.props.assert_fails);
		if (chk.fail_cnt == 0 && dut.u_cpu_sync.props.assert_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- tests/fm_chip_properties.sv
`timescale 1ns/10ps

module fm_chip_properties (
	input logic       cpu_clk,
	input logic       rst,
	input logic       cpu_cs_n,
	input logic       busy,
	input logic       write_edge,
	input logic [7:0] cpu_dout
);

	int assert_fails = 0; // failures so far

	// busy only set by a detected write
	busy_needs_write: assert property (@(posedge cpu_clk) disable iff (rst)
		$rose(busy) |-> $past(write_edge))
		else begin
			assert_fails++;
			$error("busy rose without a write edge");
		end

	open_bus: assert property (@(posedge cpu_clk) cpu_cs_n |-> cpu_dout == 8'hFF)
		else begin
			assert_fails++;
			$error("cpu_dout not FF with cs_n high");
		end

	status_unused_zero: assert property (@(posedge cpu_clk) disable iff (rst)
		!cpu_cs_n |-> cpu_dout[6:2] == 5'b00000)
		else begin
			assert_fails++;
			$error("status bits 6..2 not zero");
		end

endmodule

bind fm_cpu_sync fm_chip_properties props (
	.cpu_clk    (cpu_clk),
	.rst        (rst),
	.cpu_cs_n   (cpu_cs_n),
	.busy       (busy),
	.write_edge (write_edge),
	.cpu_dout   (cpu_dout)
);

//--- tests/fm_chip_checker.sv
`timescale 1ns/10ps
`include "fm_chip_macros.svh"

module fm_chip_checker (
	input logic       cpu_clk,
	input logic [7:0] cpu_dout,
	input logic       cpu_irq_n
);

	localparam real SYN_NS = 20.0;

	int      pass_cnt = 0;
	int      fail_cnt = 0;
	realtime irq_fall_t = -1.0; // first irq fall since arm_irq

	always @(negedge cpu_irq_n) begin
		if (irq_fall_t < 0.0)
			irq_fall_t = $realtime;
	end

	// timer model, overflow period in syn_clk cycles
	function automatic int timer_cycles(input bit is_b, input int value);
		if (is_b)
			return (256 - value) * `FM_TIMER_B_DIV * `FM_PRESCALE;
		return (1024 - value) * `FM_PRESCALE;
	endfunction

	task automatic report(input string name, input bit ok, input int exp, input int act);
		if (ok) begin
			pass_cnt++;
			$display("ok      %s", name);
		end else begin
			fail_cnt++;
			$display("FAILED  %s expected 0x%0h actual 0x%0h", name, exp, act);
		end
	endtask

	task automatic report_error(input string text);
		fail_cnt++;
		$display("%s", text);
	endtask

	task automatic arm_irq();
		irq_fall_t = -1.0;
	endtask

	// sampled mid cycle, away from both edges
	task automatic check_status(input string name, input logic [7:0] exp);
		@(negedge cpu_clk);
		report(name, cpu_dout === exp, exp, cpu_dout);
	endtask

	task automatic check_irq(input string name, input logic exp);
		@(negedge cpu_clk);
		report(name, cpu_irq_n === exp, exp, cpu_irq_n);
	endtask

	// cs_n held low by the driver while polling
	task automatic poll_busy(input string name, input int limit);
		int n;
		n = 0;
		@(negedge cpu_clk);
		if (cpu_dout[7] !== 1'b1) begin
			report(name, 1'b0, 1, cpu_dout[7]); // busy must show on first read
		end else begin
			while (cpu_dout[7] !== 1'b0 && n < limit) begin
				@(negedge cpu_clk);
				n++;
			end
			if (cpu_dout[7] !== 1'b0)
				report_error($sformatf("%s: busy bit did not clear within %0d cycles",
					name, limit));
			else
				report(name, 1'b1, 0, 0);
		end
	endtask

	task automatic check_timer(input string name, input realtime t_start, input int cycles);
		realtime lo;
		realtime hi;
		lo = t_start + (cycles - 10) * SYN_NS; // early margin
		hi = t_start + (cycles + 40) * SYN_NS; // sync and prescaler phase
		while (irq_fall_t < 0.0 && $realtime < hi)
			@(negedge cpu_clk);
		if (irq_fall_t < 0.0)
			report_error($sformatf("%s: interrupt did not arrive within %0d syn_clk cycles",
				name, cycles + 40));
		else
			report(name, irq_fall_t >= lo && irq_fall_t <= hi, cycles,
				$rtoi((irq_fall_t - t_start) / SYN_NS));
	endtask

	task automatic check_no_irq(input string name);
		if (irq_fall_t >= 0.0)
			report_error($sformatf("%s: interrupt asserted at %0.0f ns", name, irq_fall_t));
		else
			report(name, 1'b1, 0, 0);
	endtask

	task automatic wait_status(input string name, input logic [7:0] exp, input realtime hi);
		@(negedge cpu_clk);
		while (cpu_dout !== exp && $realtime < hi)
			@(negedge cpu_clk);
		report(name, cpu_dout === exp, exp, cpu_dout);
	endtask

endmodule

//--- source/fm_chip_top.sv
`timescale 1ns/10ps

module fm_chip_top (
	input  logic       cpu_clk,
	input  logic       syn_clk,
	input  logic       rst,
	input  logic [7:0] cpu_din,
	input  logic [1:0] cpu_addr,
	input  logic       cpu_cs_n,
	input  logic       cpu_wr_n,
	output logic [7:0] cpu_dout,
	output logic       cpu_irq_n
);

	import fm_chip_pkg::*;

	// cpu_clk -> syn_clk, held between writes
	logic       syn_write;
	logic [1:0] syn_addr;
	logic [7:0] syn_din;

	// syn_clk side
	logic       syn_rst;
	logic       syn_busy;
	logic       reg_we;
	fm_reg_e    reg_sel;
	logic [7:0] reg_data;
	logic       flag_a;
	logic       flag_b;
	logic       irq_n;

	fm_cpu_sync u_cpu_sync (
		.cpu_clk   (cpu_clk),
		.rst       (rst),
		.cpu_din   (cpu_din),
		.cpu_addr  (cpu_addr),
		.cpu_cs_n  (cpu_cs_n),
		.cpu_wr_n  (cpu_wr_n),
		.syn_busy  (syn_busy),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq_n     (irq_n),
		.cpu_dout  (cpu_dout),
		.cpu_irq_n (cpu_irq_n),
		.syn_write (syn_write),
		.syn_addr  (syn_addr),
		.syn_din   (syn_din)
	);

	fm_write_capture u_write_capture (
		.syn_clk   (syn_clk),
		.rst       (rst),
		.syn_write (syn_write),
		.syn_addr  (syn_addr),
		.syn_din   (syn_din),
		.syn_rst   (syn_rst),
		.syn_busy  (syn_busy),
		.reg_we    (reg_we),
		.reg_sel   (reg_sel),
		.reg_data  (reg_data)
	);

	fm_timers u_timers (
		.syn_clk  (syn_clk),
		.syn_rst  (syn_rst),
		.reg_we   (reg_we),
		.reg_sel  (reg_sel),
		.reg_data (reg_data),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq_n    (irq_n)
	);

endmodule

//--- source/fm_timers.sv
`timescale 1ns/10ps
`include "fm_chip_macros.svh"

module fm_timers (
	input  logic                 syn_clk,
	input  logic                 syn_rst,
	input  logic                 reg_we,   // one cycle
	input  fm_chip_pkg::fm_reg_e reg_sel,
	input  logic [7:0]           reg_data,
	output logic                 flag_a,
	output logic                 flag_b,
	output logic                 irq_n
);

	import fm_chip_pkg::*;

	localparam int PS_W  = $clog2(`FM_PRESCALE);
	localparam int DIV_W = $clog2(`FM_TIMER_B_DIV);

	logic [`FM_TIMER_A_W-1:0] val_a;  // reload values
	logic [`FM_TIMER_B_W-1:0] val_b;
	logic [`FM_TIMER_A_W-1:0] cnt_a;
	logic [`FM_TIMER_B_W-1:0] cnt_b;
	logic [PS_W-1:0]          presc;
	logic [DIV_W-1:0]         div_b;
	logic                     run_a;
	logic                     run_b;
	logic                     en_a;
	logic                     en_b;
	logic                     tick;
	logic                     step_b;
	logic                     ctrl_we;
	logic                     start_a;
	logic                     start_b;
	logic                     ovf_a;
	logic                     ovf_b;

	assign ctrl_we = reg_we && (reg_sel == REG_TIMER_CTRL);
	assign start_a = ctrl_we & reg_data[0] & ~run_a; // stopped -> running
	assign start_b = ctrl_we & reg_data[1] & ~run_b;

	assign tick   = (presc == PS_W'(`FM_PRESCALE - 1));
	assign step_b = tick && (div_b == DIV_W'(`FM_TIMER_B_DIV - 1));
	assign ovf_a  = run_a & tick & (&cnt_a);
	assign ovf_b  = run_b & step_b & (&cnt_b);

	// timer values, no reset
	always_ff @(posedge syn_clk) begin
		if (reg_we) begin
			case (reg_sel)
				REG_TIMER_A_HI: val_a[`FM_TIMER_A_W-1:2] <= reg_data;
				REG_TIMER_A_LO: val_a[1:0] <= reg_data[1:0];
				REG_TIMER_B:    val_b <= reg_data;
				default: ;
			endcase
		end
	end

	// control bits and free running prescaler
	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			run_a <= 1'b0;
			run_b <= 1'b0;
			en_a  <= 1'b0;
			en_b  <= 1'b0;
			presc <= '0;
		end else begin
			presc <= tick ? '0 : presc + 1'b1;
			if (ctrl_we) begin
				run_a <= reg_data[0];
				run_b <= reg_data[1];
				en_a  <= reg_data[2];
				en_b  <= reg_data[3];
			end
		end
	end

	// counters count up to all ones, then reload
	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			cnt_a <= '0;
			cnt_b <= '0;
			div_b <= '0;
		end else begin
			if (start_a)
				cnt_a <= val_a;
			else if (run_a && tick)
				cnt_a <= ovf_a ? val_a : cnt_a + 1'b1;

			if (start_b) begin
				cnt_b <= val_b;
				div_b <= '0;
			end else if (run_b && tick) begin
				div_b <= div_b + 1'b1; // wraps at FM_TIMER_B_DIV
				if (step_b)
					cnt_b <= ovf_b ? val_b : cnt_b + 1'b1;
			end
		end
	end

	// flags: reset bits clear, enabled overflow sets
	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (ctrl_we && reg_data[4])
				flag_a <= 1'b0;
			if (ctrl_we && reg_data[5])
				flag_b <= 1'b0;
			if (ovf_a && en_a)
				flag_a <= 1'b1;
			if (ovf_b && en_b)
				flag_b <= 1'b1;
		end
	end

	assign irq_n = ~(flag_a | flag_b); // active low, either flag

endmodule

//--- source/fm_write_capture.sv
`timescale 1ns/10ps
`include "fm_chip_macros.svh"

module fm_write_capture (
	input  logic                 syn_clk,
	input  logic                 rst,       // cpu side reset, seen on syn_clk
	input  logic                 syn_write, // toggle from cpu_clk
	input  logic [1:0]           syn_addr,
	input  logic [7:0]           syn_din,
	output logic                 syn_rst,
	output logic                 syn_busy,
	output logic                 reg_we,
	output fm_chip_pkg::fm_reg_e reg_sel,
	output logic [7:0]           reg_data
);

	import fm_chip_pkg::*;

	localparam int CNT_W = $clog2(`FM_WRITE_CYCLES) + 1;

	logic             rst_aux;
	logic             tog_meta;
	logic             tog_sync;
	logic             tog_old;
	logic             tog_change;
	logic             is_data;   // addr bit 0 set
	logic             is_part0;  // addr bit 1 clear
	cap_state_e       state;
	logic [CNT_W-1:0] busy_cnt;

	// syn_rst stays up two cycles past the last rst sample
	always_ff @(posedge syn_clk) begin
		if (rst) begin
			rst_aux <= 1'b1;
			syn_rst <= 1'b1;
		end else begin
			rst_aux <= 1'b0;
			syn_rst <= rst_aux;
		end
	end

	assign tog_change = tog_sync ^ tog_old;
	assign is_data    = syn_addr[0];
	assign is_part0   = ~syn_addr[1];

	always_ff @(posedge syn_clk) begin
		if (syn_rst) begin
			tog_meta <= 1'b0;
			tog_sync <= 1'b0;
			tog_old  <= 1'b0;
			state    <= CAP_IDLE;
			busy_cnt <= '0;
			reg_we   <= 1'b0;
		end else begin
			tog_meta <= syn_write; // two flop sync
			tog_sync <= tog_meta;
			tog_old  <= tog_sync;
			reg_we   <= 1'b0;
			case (state)
				CAP_IDLE: if (tog_change) begin
					state    <= CAP_BUSY;
					busy_cnt <= is_data ? CNT_W'(`FM_WRITE_CYCLES - 1)
					                    : CNT_W'(`FM_ADDR_CYCLES - 1);
					reg_we   <= is_data & is_part0; // part 1 goes nowhere
				end
				CAP_BUSY: begin
					// a toggle seen here is dropped
					if (busy_cnt == '0)
						state <= CAP_IDLE;
					else
						busy_cnt <= busy_cnt - 1'b1;
				end
				default: state <= CAP_IDLE;
			endcase
		end
	end

	// pending index and write data
	always_ff @(posedge syn_clk) begin
		if (state == CAP_IDLE && tog_change) begin
			if (!is_data && is_part0)
				reg_sel <= fm_reg_e'(syn_din);
			if (is_data)
				reg_data <= syn_din;
		end
	end

	assign syn_busy = (state == CAP_BUSY);

endmodule

//--- source/fm_cpu_sync.sv
`timescale 1ns/10ps

module fm_cpu_sync (
	input  logic       cpu_clk,
	input  logic       rst,
	input  logic [7:0] cpu_din,
	input  logic [1:0] cpu_addr,
	input  logic       cpu_cs_n,
	input  logic       cpu_wr_n,
	input  logic       syn_busy,  // syn_clk domain
	input  logic       flag_a,    // syn_clk domain
	input  logic       flag_b,    // syn_clk domain
	input  logic       irq_n,
	output logic [7:0] cpu_dout,
	output logic       cpu_irq_n,
	output logic       syn_write, // toggles once per write
	output logic [1:0] syn_addr,
	output logic [7:0] syn_din
);

	logic       write_raw;
	logic       write_old;
	logic       write_edge;
	logic       busy;       // status bit 7
	logic       busy_meta;
	logic       busy_sync;
	logic       busy_old;
	logic [1:0] flag_meta;  // {b, a}
	logic [1:0] flag_sync;

	assign write_raw  = ~cpu_cs_n & ~cpu_wr_n;
	assign write_edge = write_raw & ~write_old; // first edge with strobe active

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			write_old <= 1'b0;
			busy      <= 1'b0;
			syn_write <= 1'b0;
			busy_meta <= 1'b0;
			busy_sync <= 1'b0;
			busy_old  <= 1'b0;
			flag_meta <= 2'b00;
			flag_sync <= 2'b00;
		end else begin
			write_old <= write_raw;
			busy_meta <= syn_busy;  // two flops into cpu_clk
			busy_sync <= busy_meta;
			busy_old  <= busy_sync; // for the falling edge
			flag_meta <= {flag_b, flag_a};
			flag_sync <= flag_meta;
			if (busy && busy_old && !busy_sync)
				busy <= 1'b0; // capture side finished
			if (write_edge) begin
				busy      <= 1'b1; // new write wins over a clear
				syn_write <= ~syn_write;
			end
		end
	end

	// held until the next write
	always_ff @(posedge cpu_clk) begin
		if (write_edge) begin
			syn_addr <= cpu_addr;
			syn_din  <= cpu_din;
		end
	end

	// status byte, open bus reads FF
	assign cpu_dout = cpu_cs_n ? 8'hFF : {busy, 5'b00000, flag_sync[1], flag_sync[0]};

	assign cpu_irq_n = irq_n; // interrupt straight through

endmodule

//--- source/fm_chip_pkg.sv
package fm_chip_pkg;

	// register index as written to the address port
	typedef enum logic [7:0] {
		REG_TIMER_A_HI = 8'h24, // timer A bits 9..2
		REG_TIMER_A_LO = 8'h25, // timer A bits 1..0
		REG_TIMER_B    = 8'h26,
		REG_TIMER_CTRL = 8'h27  // run, enable, flag reset
	} fm_reg_e;

	// syn_clk side write capture
	typedef enum logic {
		CAP_IDLE = 1'b0,
		CAP_BUSY = 1'b1  // syn_busy high
	} cap_state_e;

endpackage

//--- source/fm_chip_macros.svh
`ifndef FM_CHIP_MACROS_SVH
`define FM_CHIP_MACROS_SVH

// syn_clk cycles per timer tick
`define FM_PRESCALE 6

// syn_busy length after a data-port write, in syn_clk cycles
`define FM_WRITE_CYCLES 32

// syn_busy length after an address-port write
`define FM_ADDR_CYCLES 2

// timer ticks per timer B step
`define FM_TIMER_B_DIV 16

// timer register widths
`define FM_TIMER_A_W 10
`define FM_TIMER_B_W 8

`endif
